// ==== verilog/rack_pkg.sv ====
`default_nettype none

// shared widths, register map and defaults for the rack afferent path
package rack_pkg;

    // datapath and bus widths
    localparam int DATA_W         = 32;      // register, rate, current and count words
    localparam int APB_ADDR_W     = 8;       // byte address into the register block
    localparam int GAIN_FRAC_BITS = 8;       // gain is q8.8
    localparam int CURRENT_SHIFT  = 6;       // conditioned rate -> neuron current
    localparam int DITHER_BITS    = 11;      // low current bits taken from the lfsr

    // integrate-and-fire threshold, 30 mV scaled by 1024
    localparam logic [DATA_W-1:0] NEURON_THRESHOLD = 32'd30720;

    // register reset values
    localparam logic [DATA_W-1:0] IA_OFFSET_RST = 32'd70;
    localparam logic [DATA_W-1:0] II_OFFSET_RST = 32'd50;
    localparam logic [DATA_W-1:0] IA_GAIN_RST   = 32'd307;  // 1.2 in q8.8
    localparam logic [DATA_W-1:0] II_GAIN_RST   = 32'd512;  // 2.0 in q8.8
    localparam logic [DATA_W-1:0] CLK_DIV_RST   = 32'd381;  // half real-time speed

    // dither lfsr, galois form of x^32 + x^22 + x^2 + x + 1
    localparam logic [DATA_W-1:0] LFSR_TAPS    = 32'h8020_0003;
    localparam logic [DATA_W-1:0] IA_LFSR_SEED = 32'h1d87_2b41;
    localparam logic [DATA_W-1:0] II_LFSR_SEED = 32'h6a3c_e5f9;

    // apb register map, byte addresses
    typedef enum logic [APB_ADDR_W-1:0] {
        REG_CTRL       = 8'h00,  // [0] soft sim reset, [1] dither enable
        REG_IA_OFFSET  = 8'h04,
        REG_IA_GAIN    = 8'h08,
        REG_II_OFFSET  = 8'h0C,
        REG_II_GAIN    = 8'h10,
        REG_CLK_DIV    = 8'h14,
        REG_TIME       = 8'h20,  // read only from here down
        REG_IA_COUNT   = 8'h24,
        REG_II_COUNT   = 8'h28,
        REG_IA_CURRENT = 8'h2C,
        REG_II_CURRENT = 8'h30
    } reg_addr_e;

endpackage

`default_nettype wire

// ==== verilog/apb_param_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb_param_regs
    import rack_pkg::*;
(
    input  wire logic                  ep50trig,
    input  wire logic                  reset_global,
    // apb slave
    input  wire logic                  i_psel,
    input  wire logic                  i_penable,
    input  wire logic                  i_pwrite,
    input  wire logic [APB_ADDR_W-1:0] i_paddr,
    input  wire logic [DATA_W-1:0]     i_pwdata,
    output logic      [DATA_W-1:0]     o_prdata,
    output logic                       o_pready,
    output logic                       o_pslverr,
    // rack sim reset line that is async to the host
    input  wire logic                  i_ext_reset,
    // readback sources
    input  wire logic [DATA_W-1:0]     i_time,
    input  wire logic [DATA_W-1:0]     i_ia_count,
    input  wire logic [DATA_W-1:0]     i_ii_count,
    input  wire logic [DATA_W-1:0]     i_ia_current,
    input  wire logic [DATA_W-1:0]     i_ii_current,
    // parameters out to the datapath
    output logic                       o_sim_reset,
    output logic                       o_dither_en,
    output logic      [DATA_W-1:0]     o_ia_offset,
    output logic      [DATA_W-1:0]     o_ia_gain,
    output logic      [DATA_W-1:0]     o_ii_offset,
    output logic      [DATA_W-1:0]     o_ii_gain,
    output logic      [DATA_W-1:0]     o_clk_div
);

    reg_addr_e   addr;
    logic        access;        // apb access phase
    logic        addr_hit;      // address is in the map
    logic        addr_ro;       // address is a read-only register
    logic        misaligned;
    logic        wr_en;
    logic [1:0]  ctrl_q;        // soft reset and dither enable
    logic        ext_reset_q;   // registered copy of i_ext_reset

    assign addr       = reg_addr_e'({i_paddr[APB_ADDR_W-1:2], 2'b00});   // word address decode
    assign access     = i_psel & i_penable;
    assign misaligned = |i_paddr[1:0];
    assign o_pready   = 1'b1;   // zero wait states
    assign o_pslverr  = access & (~addr_hit | misaligned | (i_pwrite & addr_ro));
    assign wr_en      = access & i_pwrite & ~o_pslverr;

    // decode and readback mux
    always_comb
    begin
        addr_hit = 1'b1;
        addr_ro  = 1'b0;
        o_prdata = '0;
        case (addr)
            REG_CTRL:       o_prdata = {{(DATA_W-2){1'b0}}, ctrl_q};
            REG_IA_OFFSET:  o_prdata = o_ia_offset;
            REG_IA_GAIN:    o_prdata = o_ia_gain;
            REG_II_OFFSET:  o_prdata = o_ii_offset;
            REG_II_GAIN:    o_prdata = o_ii_gain;
            REG_CLK_DIV:    o_prdata = o_clk_div;
            REG_TIME:       begin o_prdata = i_time;       addr_ro = 1'b1; end
            REG_IA_COUNT:   begin o_prdata = i_ia_count;   addr_ro = 1'b1; end
            REG_II_COUNT:   begin o_prdata = i_ii_count;   addr_ro = 1'b1; end
            REG_IA_CURRENT: begin o_prdata = i_ia_current; addr_ro = 1'b1; end
            REG_II_CURRENT: begin o_prdata = i_ii_current; addr_ro = 1'b1; end
            default:        addr_hit = 1'b0;   // hole in the map
        endcase
    end

    // writable registers load at the edge that closes the access phase
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            ctrl_q      <= 2'b00;
            o_ia_offset <= IA_OFFSET_RST;
            o_ia_gain   <= IA_GAIN_RST;
            o_ii_offset <= II_OFFSET_RST;
            o_ii_gain   <= II_GAIN_RST;
            o_clk_div   <= CLK_DIV_RST;
        end
        else if (wr_en)
        begin
            case (addr)
                REG_CTRL:      ctrl_q      <= i_pwdata[1:0];
                REG_IA_OFFSET: o_ia_offset <= i_pwdata;
                REG_IA_GAIN:   o_ia_gain   <= i_pwdata;
                REG_II_OFFSET: o_ii_offset <= i_pwdata;
                REG_II_GAIN:   o_ii_gain   <= i_pwdata;
                REG_CLK_DIV:   o_clk_div   <= i_pwdata;
                default:       ;               // read-only addresses never write
            endcase
        end
    end

    // one-cycle registered copy of the rack reset line
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
            ext_reset_q <= 1'b0;
        else
            ext_reset_q <= i_ext_reset;
    end

    assign o_sim_reset = ctrl_q[0] | ext_reset_q;   // held while ctrl bit 0 is set
    assign o_dither_en = ctrl_q[1];

endmodule

`default_nettype wire

// ==== verilog/sim_timebase.sv ====
`timescale 1ns/1ps
`default_nettype none

module sim_timebase
    import rack_pkg::*;
(
    input  wire logic              ep50trig,
    input  wire logic              reset_global,
    input  wire logic [DATA_W-1:0] i_clk_div,   // tick period is i_clk_div + 1
    output logic                   o_tick,      // one simulation step
    output logic      [DATA_W-1:0] o_time       // tick count, the time tag
);

    logic [DATA_W-1:0] div_cnt;

    // >= so that lowering clk_div below the running count still ticks
    assign o_tick = (div_cnt >= i_clk_div);

    // divide counter wraps on the tick
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
            div_cnt <= '0;
        else if (o_tick)
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + 1'b1;
    end

    // time tag, only the global reset clears it
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
            o_time <= '0;
        else if (o_tick)
            o_time <= o_time + 1'b1;
    end

endmodule

`default_nettype wire

// ==== verilog/afferent_conditioner.sv ====
`timescale 1ns/1ps
`default_nettype none

module afferent_conditioner
    import rack_pkg::*;
#(
    parameter logic [DATA_W-1:0] LFSR_SEED = IA_LFSR_SEED  // nonzero
)
(
    input  wire logic              ep50trig,
    input  wire logic              reset_global,
    input  wire logic              i_sim_reset,
    input  wire logic              i_dither_en,
    input  wire logic [DATA_W-1:0] i_rate,      // afferent rate, pps
    input  wire logic [DATA_W-1:0] i_offset,    // pps removed from the rate
    input  wire logic [DATA_W-1:0] i_gain,      // q8.8
    output logic      [DATA_W-1:0] o_current    // neuron input current
);

    logic [DATA_W-1:0]   rate_s1;    // offset removed, clamped
    logic [DATA_W-1:0]   gain_s2;    // after the q8.8 gain
    logic [2*DATA_W-1:0] product;
    logic [DATA_W-1:0]   shifted;
    logic [DATA_W-1:0]   lfsr;

    assign product = rate_s1 * i_gain;
    assign shifted = gain_s2 << CURRENT_SHIFT;

    // three stage pipe, sim reset flushes it
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            rate_s1   <= '0;
            gain_s2   <= '0;
            o_current <= '0;
        end
        else if (i_sim_reset)
        begin
            rate_s1   <= '0;
            gain_s2   <= '0;
            o_current <= '0;
        end
        else
        begin
            rate_s1 <= (i_rate > i_offset) ? i_rate - i_offset : '0;       // no negative rates
            gain_s2 <= product[GAIN_FRAC_BITS +: DATA_W];                 // drop the fraction
            if (i_dither_en)
                o_current <= {shifted[DATA_W-1:DITHER_BITS], lfsr[DITHER_BITS-1:0]};
            else
                o_current <= shifted;
        end
    end

    // galois lfsr, free running, reseeded on sim reset
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
            lfsr <= LFSR_SEED;
        else if (i_sim_reset)
            lfsr <= LFSR_SEED;
        else
            lfsr <= {1'b0, lfsr[DATA_W-1:1]} ^ (lfsr[0] ? LFSR_TAPS : '0);
    end

endmodule

`default_nettype wire

// ==== verilog/spiking_neuron.sv ====
`timescale 1ns/1ps
`default_nettype none

module spiking_neuron
    import rack_pkg::*;
(
    input  wire logic              ep50trig,
    input  wire logic              reset_global,
    input  wire logic              i_sim_reset,
    input  wire logic [DATA_W-1:0] i_current,   // added to the potential every cycle
    output logic                   o_spike      // one cycle per firing
);

    logic [DATA_W-1:0] v;       // membrane potential
    logic [DATA_W:0]   v_next;  // one extra bit so a large current cannot wrap
    logic              fire;

    assign v_next = {1'b0, v} + {1'b0, i_current};
    assign fire   = (v_next >= {1'b0, NEURON_THRESHOLD});

    // integrate and fire, potential back to rest after a spike
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            v       <= '0;
            o_spike <= 1'b0;
        end
        else if (i_sim_reset)
        begin
            v       <= '0;
            o_spike <= 1'b0;
        end
        else if (fire)
        begin
            v       <= '0;
            o_spike <= 1'b1;    // seen the cycle after the crossing
        end
        else
        begin
            v       <= v_next[DATA_W-1:0];  // below threshold, top bit is 0
            o_spike <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/spike_window_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module spike_window_counter
    import rack_pkg::*;
(
    input  wire logic              ep50trig,
    input  wire logic              reset_global,
    input  wire logic              i_sim_reset,
    input  wire logic              i_tick,      // closes the window
    input  wire logic              i_spike,
    output logic      [DATA_W-1:0] o_count      // spikes in the last full window
);

    logic [DATA_W-1:0] running;

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            running <= '0;
            o_count <= '0;
        end
        else if (i_sim_reset)
        begin
            running <= '0;
            o_count <= '0;
        end
        else if (i_tick)
        begin
            o_count <= running + DATA_W'(i_spike);  // a spike on the tick still counts
            running <= '0;
        end
        else
            running <= running + DATA_W'(i_spike);
    end

endmodule

`default_nettype wire

// ==== verilog/rack_afferent_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rack_afferent_top
    import rack_pkg::*;
(
    input  wire logic                  ep50trig,
    input  wire logic                  reset_global,
    // apb from the host
    input  wire logic                  i_psel,
    input  wire logic                  i_penable,
    input  wire logic                  i_pwrite,
    input  wire logic [APB_ADDR_W-1:0] i_paddr,
    input  wire logic [DATA_W-1:0]     i_pwdata,
    output logic      [DATA_W-1:0]     o_prdata,
    output logic                       o_pready,
    output logic                       o_pslverr,
    // afferent rates, pps
    input  wire logic [DATA_W-1:0]     i_ia_rate,
    input  wire logic [DATA_W-1:0]     i_ii_rate,
    input  wire logic                  i_ext_reset,  // rack reset line
    output logic                       o_ia_spike,
    output logic                       o_ii_spike,
    output logic                       o_tick
);

    logic              sim_reset;
    logic              dither_en;
    logic [DATA_W-1:0] ia_offset, ia_gain, ii_offset, ii_gain;
    logic [DATA_W-1:0] clk_div;
    logic [DATA_W-1:0] sim_time;
    logic [DATA_W-1:0] ia_current, ii_current;
    logic [DATA_W-1:0] ia_count, ii_count;

    apb_param_regs u_regs (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_psel       (i_psel),
        .i_penable    (i_penable),
        .i_pwrite     (i_pwrite),
        .i_paddr      (i_paddr),
        .i_pwdata     (i_pwdata),
        .o_prdata     (o_prdata),
        .o_pready     (o_pready),
        .o_pslverr    (o_pslverr),
        .i_ext_reset  (i_ext_reset),
        .i_time       (sim_time),
        .i_ia_count   (ia_count),
        .i_ii_count   (ii_count),
        .i_ia_current (ia_current),
        .i_ii_current (ii_current),
        .o_sim_reset  (sim_reset),
        .o_dither_en  (dither_en),
        .o_ia_offset  (ia_offset),
        .o_ia_gain    (ia_gain),
        .o_ii_offset  (ii_offset),
        .o_ii_gain    (ii_gain),
        .o_clk_div    (clk_div)
    );

    sim_timebase u_timebase (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_clk_div    (clk_div),
        .o_tick       (o_tick),
        .o_time       (sim_time)
    );

    // ia channel
    afferent_conditioner #(.LFSR_SEED(IA_LFSR_SEED)) u_cond_ia (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_sim_reset  (sim_reset),
        .i_dither_en  (dither_en),
        .i_rate       (i_ia_rate),
        .i_offset     (ia_offset),
        .i_gain       (ia_gain),
        .o_current    (ia_current)
    );

    spiking_neuron u_neuron_ia (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_sim_reset  (sim_reset),
        .i_current    (ia_current),
        .o_spike      (o_ia_spike)
    );

    spike_window_counter u_count_ia (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_sim_reset  (sim_reset),
        .i_tick       (o_tick),
        .i_spike      (o_ia_spike),
        .o_count      (ia_count)
    );

    // ii channel
    afferent_conditioner #(.LFSR_SEED(II_LFSR_SEED)) u_cond_ii (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_sim_reset  (sim_reset),
        .i_dither_en  (dither_en),
        .i_rate       (i_ii_rate),
        .i_offset     (ii_offset),
        .i_gain       (ii_gain),
        .o_current    (ii_current)
    );

    spiking_neuron u_neuron_ii (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_sim_reset  (sim_reset),
        .i_current    (ii_current),
        .o_spike      (o_ii_spike)
    );

    spike_window_counter u_count_ii (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_sim_reset  (sim_reset),
        .i_tick       (o_tick),
        .i_spike      (o_ii_spike),
        .o_count      (ii_count)
    );

endmodule

`default_nettype wire

// ==== dv/rack_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module rack_assertions
    import rack_pkg::*;
(
    input  wire logic              ep50trig,
    input  wire logic              reset_global,
    input  wire logic              i_psel,
    input  wire logic              i_penable,
    input  wire logic              i_pready,
    input  wire logic              i_pslverr,
    input  wire logic              i_tick,
    input  wire logic [DATA_W-1:0] i_clk_div,
    input  wire logic              i_sim_reset,
    input  wire logic [DATA_W-1:0] i_ia_count,
    input  wire logic [DATA_W-1:0] i_ii_count
);

    int fail_count = 0;   // failed assertions so far

    a_pready_high: assert property (@(posedge ep50trig) disable iff (reset_global) i_pready)
    else
    begin
        $error("o_pready went low");
        fail_count++;
    end

    // slave error only while an access phase is open
    a_pslverr_access: assert property (@(posedge ep50trig) disable iff (reset_global)
                                       i_pslverr |-> (i_psel && i_penable))
    else
    begin
        $error("o_pslverr high outside an access phase");
        fail_count++;
    end

    a_tick_single: assert property (@(posedge ep50trig) disable iff (reset_global)
                                    (i_tick && i_clk_div != '0) |=> !i_tick)
    else
    begin
        $error("o_tick high for two cycles in a row");
        fail_count++;
    end

    a_counts_cleared: assert property (@(posedge ep50trig) disable iff (reset_global)
                                       i_sim_reset |=> (i_ia_count == '0 && i_ii_count == '0))
    else
    begin
        $error("spike counts not cleared after a simulation reset");
        fail_count++;
    end

endmodule

bind rack_afferent_top rack_assertions u_assertions (
    .ep50trig     (ep50trig),
    .reset_global (reset_global),
    .i_psel       (i_psel),
    .i_penable    (i_penable),
    .i_pready     (o_pready),
    .i_pslverr    (o_pslverr),
    .i_tick       (o_tick),
    .i_clk_div    (clk_div),
    .i_sim_reset  (sim_reset),
    .i_ia_count   (ia_count),
    .i_ii_count   (ii_count)
);

`default_nettype wire

// ==== dv/rack_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rack_tb
    import rack_pkg::*;
();

    localparam int WINDOW     = 200;     // cycles per simulation tick in the spike tests
    localparam int MAX_CYCLES = 20000;   // whole run is a few thousand cycles

    logic                  ep50trig = 1'b0;
    logic                  reset_global;
    logic                  i_psel;
    logic                  i_penable;
    logic                  i_pwrite;
    logic [APB_ADDR_W-1:0] i_paddr;
    logic [DATA_W-1:0]     i_pwdata;
    logic [DATA_W-1:0]     i_ia_rate;
    logic [DATA_W-1:0]     i_ii_rate;
    logic                  i_ext_reset;
    logic [DATA_W-1:0]     o_prdata;
    logic                  o_pready;
    logic                  o_pslverr;
    logic                  o_ia_spike;
    logic                  o_ii_spike;
    logic                  o_tick;

    logic [31:0] lcg_state = 32'hb49f_fc53;
    int          checks = 0;
    int          errors = 0;
    int          cycles = 0;
    int          prev_total = 0;   // error total at the end of the previous test

    // pending comparisons that the compare process drains
    string       name_q[$];
    logic [31:0] exp_q[$];
    logic [31:0] act_q[$];
    int          tol_q[$];
    time         when_q[$];
    string       cmp_name;
    logic [31:0] cmp_exp;
    logic [31:0] cmp_act;
    int          cmp_tol;
    time         cmp_when;

    rack_afferent_top UUT (.*);

    always #50 ep50trig = ~ep50trig;   // 100 ns period

    // watchdog
    always @(posedge ep50trig)
    begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout: the run did not end within %0d cycles", MAX_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    // compare process runs once per falling edge
    always @(negedge ep50trig)
    begin
        while (name_q.size() > 0)
        begin
            cmp_name = name_q.pop_front();
            cmp_exp  = exp_q.pop_front();
            cmp_act  = act_q.pop_front();
            cmp_tol  = tol_q.pop_front();
            cmp_when = when_q.pop_front();
            checks++;
            assert ((cmp_act + cmp_tol >= cmp_exp) && (cmp_act <= cmp_exp + cmp_tol))
            else
            begin
                $display("CHECK FAILED at %0t: %s expected %0d (tolerance %0d), got %0d",
                         cmp_when, cmp_name, cmp_exp, cmp_tol, cmp_act);
                errors++;
            end
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // offset clamp and q8.8 gain and then scale up to a neuron current
    function automatic logic [31:0] current_ref(input logic [31:0] rate,
                                                input logic [31:0] offset,
                                                input logic [31:0] gain);
        logic [31:0] diff;
        logic [63:0] prod;
        diff = (rate > offset) ? rate - offset : 32'd0;
        prod = (64'(diff) * 64'(gain)) >> GAIN_FRAC_BITS;
        return prod[31:0] << CURRENT_SHIFT;
    endfunction

    function automatic logic [31:0] spike_period(input logic [31:0] c);
        return (NEURON_THRESHOLD + c - 1) / c;   // ceil(threshold / c)
    endfunction

    function automatic logic [31:0] window_count(input logic [31:0] w, input logic [31:0] p);
        return w / p;
    endfunction

    function automatic int total_errors();
        return errors + UUT.u_assertions.fail_count;
    endfunction

    task automatic push_check(input string name, input logic [31:0] exp,
                              input logic [31:0] act, input int tol);
        name_q.push_back(name);
        exp_q.push_back(exp);
        act_q.push_back(act);
        tol_q.push_back(tol);
        when_q.push_back($time);
    endtask

    // setup on one falling edge and access on the next with sampling at the closing rising edge
    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        @(negedge ep50trig);
        i_psel    = 1'b1;
        i_penable = 1'b0;
        i_pwrite  = wr;
        i_paddr   = addr;
        i_pwdata  = wdata;
        @(negedge ep50trig);
        i_penable = 1'b1;
        @(posedge ep50trig);   // access phase ends here with pready high
        rdata = o_prdata;
        err   = o_pslverr;
        @(negedge ep50trig);
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] unused;
        apb_access(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        logic err;
        apb_access(1'b0, addr, 32'd0, data, err);
        push_check("o_pslverr on read", 32'd0, 32'(err), 0);
    endtask

    task automatic wait_tick();
        @(negedge ep50trig);
        while (!o_tick)
            @(negedge ep50trig);
    endtask

    // cycles between two successive spikes of one channel
    task automatic measure_spike_gap(input bit ii_channel, output int gap);
        @(negedge ep50trig);
        while (!(ii_channel ? o_ii_spike : o_ia_spike))
            @(negedge ep50trig);
        gap = 0;
        do
        begin
            @(negedge ep50trig);
            gap++;
        end while (!(ii_channel ? o_ii_spike : o_ia_spike));
    endtask

    task automatic finish_test(input string name);
        int total;
        while (name_q.size() > 0)
            @(negedge ep50trig);
        total = total_errors();
        $display("test %s: %0d errors", name, total - prev_total);
        prev_total = total;
    endtask

    initial
    begin
        logic [31:0] rd;
        logic [31:0] t_prev;
        logic [31:0] n;
        logic [31:0] ia_off, ia_gain, ii_off, ii_gain, ia_r, ii_r;
        logic [31:0] low_ia, low_ii;
        logic [31:0] p_ia, p_ii;
        logic [31:0] wr_val [5];
        logic [7:0]  rw_addr [5];
        logic [31:0] rw_rst [5];
        logic [7:0]  bad_addr [4];
        logic        err, changed_ia, changed_ii;
        int          gap, seen;

        reset_global = 1'b1;
        i_psel       = 1'b0;
        i_penable    = 1'b0;
        i_pwrite     = 1'b0;
        i_paddr      = '0;
        i_pwdata     = '0;
        i_ia_rate    = '0;
        i_ii_rate    = '0;
        i_ext_reset  = 1'b0;
        rw_addr  = '{REG_IA_OFFSET, REG_IA_GAIN, REG_II_OFFSET, REG_II_GAIN, REG_CLK_DIV};
        rw_rst   = '{IA_OFFSET_RST, IA_GAIN_RST, II_OFFSET_RST, II_GAIN_RST, CLK_DIV_RST};
        bad_addr = '{REG_TIME, REG_IA_CURRENT, 8'h18, 8'h05};   // two read-only then a hole
        repeat (4) @(negedge ep50trig);
        reset_global = 1'b0;

        // test 1 covers defaults and write readback and rejected writes
        for (int i = 0; i < 5; i++)
        begin
            apb_read(rw_addr[i], rd);
            push_check("o_prdata default", rw_rst[i], rd, 0);
        end
        apb_read(REG_CTRL, rd);
        push_check("REG_CTRL default", 32'd0, rd, 0);
        for (int i = 0; i < 5; i++)
        begin
            wr_val[i] = lcg_next();
            apb_write(rw_addr[i], wr_val[i], err);
            push_check("o_pslverr on write", 32'd0, 32'(err), 0);
            apb_read(rw_addr[i], rd);
            push_check("o_prdata after write", wr_val[i], rd, 0);
        end
        apb_write(REG_CTRL, 32'd2, err);   // dither on with sim reset off
        apb_read(REG_CTRL, rd);
        push_check("REG_CTRL", 32'd2, rd, 0);
        apb_write(REG_CTRL, 32'd0, err);
        for (int i = 0; i < 4; i++)
        begin
            apb_write(bad_addr[i], 32'hdead_beef, err);
            push_check("o_pslverr on bad write", 32'd1, 32'(err), 0);
        end
        apb_access(1'b0, 8'h3C, 32'd0, rd, err);
        push_check("o_pslverr on unmapped read", 32'd1, 32'(err), 0);
        for (int i = 0; i < 5; i++)
        begin
            apb_read(rw_addr[i], rd);
            push_check("o_prdata after bad writes", wr_val[i], rd, 0);
        end
        finish_test("1 register map");

        // test 2 checks the tick period and time tag
        n = 32'd4 + (lcg_next() % 32'd8);   // keeps a read inside one tick period
        apb_write(REG_CLK_DIV, n, err);
        wait_tick();
        for (int i = 0; i < 3; i++)
        begin
            gap = 0;
            do
            begin
                @(negedge ep50trig);
                gap++;
            end while (!o_tick);
            push_check("o_tick period", n + 1, gap, 0);
        end
        wait_tick();
        apb_read(REG_TIME, t_prev);
        for (int i = 0; i < 3; i++)
        begin
            wait_tick();
            apb_read(REG_TIME, rd);
            push_check("REG_TIME step", t_prev + 1, rd, 0);
            t_prev = rd;
        end
        finish_test("2 timebase");

        // test 3 checks conditioned currents without dither
        for (int round = 0; round < 6; round++)
        begin
            ia_off  = lcg_next() % 200;
            ia_gain = lcg_next() % 1024;
            ii_off  = lcg_next() % 200;
            ii_gain = lcg_next() % 1024;
            ia_r    = lcg_next() % 1000;
            ii_r    = lcg_next() % 1000;
            if (round == 0)
                ia_r = ia_off / 2;   // under the offset so it clamps to 0
            apb_write(REG_IA_OFFSET, ia_off, err);
            apb_write(REG_IA_GAIN, ia_gain, err);
            apb_write(REG_II_OFFSET, ii_off, err);
            apb_write(REG_II_GAIN, ii_gain, err);
            @(negedge ep50trig);
            i_ia_rate = ia_r;
            i_ii_rate = ii_r;
            repeat (4) @(negedge ep50trig);   // pipe is 3 deep
            apb_read(REG_IA_CURRENT, rd);
            push_check("REG_IA_CURRENT", current_ref(ia_r, ia_off, ia_gain), rd, 0);
            apb_read(REG_II_CURRENT, rd);
            push_check("REG_II_CURRENT", current_ref(ii_r, ii_off, ii_gain), rd, 0);
        end
        finish_test("3 currents");

        // test 4 where dither keeps the upper bits and moves the low 11
        apb_write(REG_CTRL, 32'd2, err);
        changed_ia = 1'b0;
        changed_ii = 1'b0;
        for (int k = 0; k < 4; k++)
        begin
            apb_read(REG_IA_CURRENT, rd);
            push_check("REG_IA_CURRENT[31:11]",
                       current_ref(ia_r, ia_off, ia_gain) >> DITHER_BITS, rd >> DITHER_BITS, 0);
            if (k == 0)
                low_ia = rd & 32'h7ff;
            else if ((rd & 32'h7ff) != low_ia)
                changed_ia = 1'b1;
            apb_read(REG_II_CURRENT, rd);
            push_check("REG_II_CURRENT[31:11]",
                       current_ref(ii_r, ii_off, ii_gain) >> DITHER_BITS, rd >> DITHER_BITS, 0);
            if (k == 0)
                low_ii = rd & 32'h7ff;
            else if ((rd & 32'h7ff) != low_ii)
                changed_ii = 1'b1;
        end
        checks++;
        assert (changed_ia && changed_ii)
        else
        begin
            $display("dither low bits stayed the same over successive current reads");
            errors++;
        end
        apb_write(REG_CTRL, 32'd0, err);
        finish_test("4 dither");

        // test 5 covers spike periods and window counts at constant rates
        for (int i = 0; i < 4; i++)
            apb_write(rw_addr[i], rw_rst[i], err);
        apb_write(REG_CLK_DIV, WINDOW - 1, err);
        ia_r = IA_OFFSET_RST + 30 + (lcg_next() % 170);   // periods of 3 to 14 cycles
        ii_r = II_OFFSET_RST + 15 + (lcg_next() % 100);
        p_ia = spike_period(current_ref(ia_r, IA_OFFSET_RST, IA_GAIN_RST));
        p_ii = spike_period(current_ref(ii_r, II_OFFSET_RST, II_GAIN_RST));
        @(negedge ep50trig);
        i_ia_rate = ia_r;
        i_ii_rate = ii_r;
        wait_tick();
        wait_tick();   // one whole window at the new rates
        apb_read(REG_IA_COUNT, rd);
        push_check("REG_IA_COUNT", window_count(WINDOW, p_ia), rd, 1);
        apb_read(REG_II_COUNT, rd);
        push_check("REG_II_COUNT", window_count(WINDOW, p_ii), rd, 1);
        for (int i = 0; i < 2; i++)
        begin
            measure_spike_gap(1'b0, gap);
            push_check("o_ia_spike period", p_ia, gap, 0);
            measure_spike_gap(1'b1, gap);
            push_check("o_ii_spike period", p_ii, gap, 0);
        end
        finish_test("5 spikes");

        // test 6 holds the soft reset in CTRL and then pulses the rack line
        apb_write(REG_CTRL, 32'd1, err);
        apb_read(REG_TIME, t_prev);
        apb_read(REG_IA_COUNT, rd);
        push_check("REG_IA_COUNT under reset", 32'd0, rd, 0);
        apb_read(REG_II_COUNT, rd);
        push_check("REG_II_COUNT under reset", 32'd0, rd, 0);
        seen = 0;
        repeat (250)
        begin
            @(negedge ep50trig);
            if (o_ia_spike || o_ii_spike)
                seen++;
        end
        push_check("o_ia_spike/o_ii_spike under CTRL reset", 32'd0, seen, 0);
        apb_read(REG_TIME, rd);
        checks++;
        assert (rd > t_prev)
        else
        begin
            $display("TIME stopped advancing while the simulation reset was held");
            errors++;
        end
        apb_write(REG_CTRL, 32'd0, err);
        wait_tick();
        wait_tick();
        apb_read(REG_IA_COUNT, rd);
        checks++;
        assert (rd != 0)
        else
        begin
            $display("Ia count still zero after release, the external reset has nothing to clear");
            errors++;
        end
        wait_tick();   // keeps the next tick well clear of the reads below
        @(negedge ep50trig);
        i_ext_reset = 1'b1;
        @(negedge ep50trig);
        i_ext_reset = 1'b0;
        @(negedge ep50trig);   // first cycle after the clear
        seen = 0;
        // a neuron that missed the clear fires within one spike period
        for (int k = 0; k < ((p_ia > p_ii) ? p_ia : p_ii); k++)
        begin
            if ((k < p_ia && o_ia_spike) || (k < p_ii && o_ii_spike))
                seen++;
            @(negedge ep50trig);
        end
        push_check("o_ia_spike/o_ii_spike after ext reset", 32'd0, seen, 0);
        apb_read(REG_IA_COUNT, rd);
        push_check("REG_IA_COUNT after ext reset", 32'd0, rd, 0);
        apb_read(REG_II_COUNT, rd);
        push_check("REG_II_COUNT after ext reset", 32'd0, rd, 0);
        finish_test("6 simulation reset");

        $display("%0d checks, %0d errors", checks, total_errors());
        if (total_errors() == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/rack_pkg.sv
verilog/apb_param_regs.sv
verilog/sim_timebase.sv
verilog/afferent_conditioner.sv
verilog/spiking_neuron.sv
verilog/spike_window_counter.sv
verilog/rack_afferent_top.sv
dv/rack_assertions.sv
dv/rack_tb.sv

// ==== Bender.yml ====
package:
  name: rack_afferent

sources:
  - verilog/rack_pkg.sv
  - verilog/apb_param_regs.sv
  - verilog/sim_timebase.sv
  - verilog/afferent_conditioner.sv
  - verilog/spiking_neuron.sv
  - verilog/spike_window_counter.sv
  - verilog/rack_afferent_top.sv
  - target: simulation
    files:
      - dv/rack_assertions.sv
      - dv/rack_tb.sv
